// ==== hw/etx_macros.svh ====
/*
 Fixed link geometry shared by the whole transmit path, so no module takes parameters
 FIFO depth must be at least 2
*/
`ifndef ETX_MACROS_SVH
`define ETX_MACROS_SVH

// Width of one mesh transaction
`define ETX_PW 104

// Lowest bit of the 4-bit control-mode field
`define ETX_CTRL_LSB 4

// Entries held per source FIFO
`define ETX_FIFO_DEPTH 4

`endif

// ==== hw/etx_pkg.sv ====
/*
 Types for the transmit path, sized from the link macros
*/
`default_nettype none

`include "etx_macros.svh"

package etx_pkg;

  // One mesh transaction as it leaves a FIFO
  typedef logic [`ETX_PW-1:0] packet_t;

  // Control-mode field, bits 7 to 4 of a packet
  typedef logic [3:0] ctrlmode_t;

  // Occupancy, needs room for the full value
  typedef logic [$clog2(`ETX_FIFO_DEPTH+1)-1:0] fifo_count_t;

  // I/O stage states
  typedef enum logic [0:0] {
    io_idle,
    io_send
  } io_state_t;

endpackage

`default_nettype wire

// ==== hw/etx_if.sv ====
/*
 Arbiter to I/O stage channel; the wait levels come in from the link partner via the top
*/
`timescale 1ns/1ps
`default_nettype none

interface etx_if;
  import etx_pkg::*;

  // Transaction offered by the arbiter
  logic    etx_access;
  packet_t etx_packet;

  // Taken by the I/O stage
  logic    etx_ack;

  // Back-pressure from the far side
  logic    etx_rd_wait;
  logic    etx_wr_wait;

  modport arb (
    output etx_access,
    output etx_packet,
    input  etx_ack,
    input  etx_rd_wait,
    input  etx_wr_wait
  );

  modport io (
    input  etx_access,
    input  etx_packet,
    output etx_ack
  );

endinterface

`default_nettype wire

// ==== hw/etx_fifo.sv ====
/*
 First-word-fall-through; head_packet is valid whenever empty is low
 Pushing while full or popping while empty is illegal
*/
`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module etx_fifo (
  input  logic             tx_lclk_div4,
  input  logic             reset,
  input  logic             push,
  input  etx_pkg::packet_t push_packet,
  input  logic             pop,
  output logic             full,
  output logic             empty,
  output etx_pkg::packet_t head_packet
);
  import etx_pkg::*;

  localparam int unsigned PTR_W = $clog2(`ETX_FIFO_DEPTH);

  packet_t           mem [`ETX_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  fifo_count_t       count;

  // Wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`ETX_FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // ########################################
  // Status from occupancy
  // ########################################
  assign empty       = (count == '0);
  assign full        = (count == fifo_count_t'(`ETX_FIFO_DEPTH));
  assign head_packet = mem[rd_ptr];

  // Storage, no reset on payload
  always_ff @(posedge tx_lclk_div4)
  begin
    if (push)
      mem[wr_ptr] <= push_packet;
  end

  // Pointers and count
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Source must watch full
  a_no_push_full: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    !(push && full));

  // Arbiter must only read a non-empty FIFO
  a_no_pop_empty: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    !(pop && empty));

endmodule

`default_nettype wire

// ==== hw/etx_arbiter.sv ====
/*
 Fixed priority writes, read requests, read responses; no round-robin, so a
 steady write stream starves the others
*/
`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module etx_arbiter (
  input  logic               tx_lclk_div4,
  input  logic               reset,
  input  logic               ecfg_tx_ctrlmode_bp,
  input  etx_pkg::ctrlmode_t ecfg_tx_ctrlmode,
  input  logic               txwr_fifo_empty,
  input  etx_pkg::packet_t   txwr_fifo_packet,
  output logic               txwr_fifo_read,
  input  logic               txrd_fifo_empty,
  input  etx_pkg::packet_t   txrd_fifo_packet,
  output logic               txrd_fifo_read,
  input  logic               txrr_fifo_empty,
  input  etx_pkg::packet_t   txrr_fifo_packet,
  output logic               txrr_fifo_read,
  etx_if.arb                 etx
);
  import etx_pkg::*;

  logic    wr_ready;
  logic    rd_ready;
  logic    rr_ready;
  logic    slot_free;
  logic    any_read;
  packet_t txwr_packet_mod;
  packet_t txrd_packet_mod;
  packet_t next_packet;

  // Swap in the configured control mode when bypass is set
  function automatic packet_t apply_ctrlmode(input packet_t pkt, input logic bp,
                                             input ctrlmode_t mode);
    packet_t result;
    result = pkt;
    if (bp)
      result[`ETX_CTRL_LSB +: $bits(ctrlmode_t)] = mode;
    return result;
  endfunction

  // ########################################
  // Eligibility and read strobes
  // ########################################

  // Writes highest
  assign wr_ready = !txwr_fifo_empty && !etx.etx_wr_wait;
  assign rd_ready = !txrd_fifo_empty && !etx.etx_rd_wait && !wr_ready;
  // Responses also blocked by write wait
  assign rr_ready = !txrr_fifo_empty && !etx.etx_wr_wait && !wr_ready && !rd_ready;

  // Output register empty or being taken this cycle
  assign slot_free = !etx.etx_access || etx.etx_ack;

  assign txwr_fifo_read = wr_ready && slot_free;
  assign txrd_fifo_read = rd_ready && slot_free;
  assign txrr_fifo_read = rr_ready && slot_free;
  assign any_read       = txwr_fifo_read || txrd_fifo_read || txrr_fifo_read;

  // ########################################
  // Control-mode override and select
  // ########################################
  assign txwr_packet_mod = apply_ctrlmode(txwr_fifo_packet, ecfg_tx_ctrlmode_bp,
                                          ecfg_tx_ctrlmode);
  assign txrd_packet_mod = apply_ctrlmode(txrd_fifo_packet, ecfg_tx_ctrlmode_bp,
                                          ecfg_tx_ctrlmode);

  // Strobes are one-hot, order only matters for the default
  always_comb
  begin
    if (txwr_fifo_read)
      next_packet = txwr_packet_mod;
    else if (txrd_fifo_read)
      next_packet = txrd_packet_mod;
    else
      // Responses pass untouched
      next_packet = txrr_fifo_packet;
  end

  // ########################################
  // Output register
  // ########################################
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
      etx.etx_access <= 1'b0;
    else if (any_read)
      etx.etx_access <= 1'b1;
    else if (etx.etx_ack)
      etx.etx_access <= 1'b0;
  end

  // Loaded on the same edge as the pop
  always_ff @(posedge tx_lclk_div4)
  begin
    if (any_read)
      etx.etx_packet <= next_packet;
  end

  a_read_onehot: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $onehot0({txwr_fifo_read, txrd_fifo_read, txrr_fifo_read}));

  // Offer held until the I/O stage acks it
  a_packet_held: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    etx.etx_access && !etx.etx_ack |=> etx.etx_access && $stable(etx.etx_packet));

endmodule

`default_nettype wire

// ==== hw/etx_io.sv ====
/*
 One packet in flight; a new packet is accepted only a cycle after tx_ready takes the old one
*/
`timescale 1ns/1ps
`default_nettype none

module etx_io (
  input  logic             tx_lclk_div4,
  input  logic             reset,
  etx_if.io                etx,
  input  logic             tx_ready,
  output logic             tx_valid,
  output etx_pkg::packet_t tx_packet
);
  import etx_pkg::*;

  io_state_t state;

  // Ack straight back while idle
  assign etx.etx_ack = (state == io_idle) && etx.etx_access;
  assign tx_valid    = (state == io_send);

  // ########################################
  // State machine
  // ########################################
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
      state <= io_idle;
    else
    begin
      case (state)
        io_idle:
          if (etx.etx_ack)
            state <= io_send;
        io_send:
          // Receiver took it
          if (tx_ready)
            state <= io_idle;
        default:
          state <= io_idle;
      endcase
    end
  end

  // Capture on the ack edge
  always_ff @(posedge tx_lclk_div4)
  begin
    if (etx.etx_ack)
      tx_packet <= etx.etx_packet;
  end

  a_tx_hold: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_packet));

endmodule

`default_nettype wire

// ==== hw/etx_top.sv ====
/*
 Three source FIFOs into one transmit channel; wait levels must come from the tx clock domain
*/
`timescale 1ns/1ps
`default_nettype none

module etx_top (
  input  logic               tx_lclk_div4,
  input  logic               reset,
  input  logic               ecfg_tx_ctrlmode_bp,
  input  etx_pkg::ctrlmode_t ecfg_tx_ctrlmode,
  input  logic               wr_push,
  input  etx_pkg::packet_t   wr_packet,
  output logic               wr_full,
  input  logic               rd_push,
  input  etx_pkg::packet_t   rd_packet,
  output logic               rd_full,
  input  logic               rr_push,
  input  etx_pkg::packet_t   rr_packet,
  output logic               rr_full,
  input  logic               etx_rd_wait,
  input  logic               etx_wr_wait,
  input  logic               tx_ready,
  output logic               tx_valid,
  output etx_pkg::packet_t   tx_packet
);
  import etx_pkg::*;

  // FIFO to arbiter channels
  logic    txwr_fifo_empty;
  logic    txwr_fifo_read;
  packet_t txwr_fifo_packet;
  logic    txrd_fifo_empty;
  logic    txrd_fifo_read;
  packet_t txrd_fifo_packet;
  logic    txrr_fifo_empty;
  logic    txrr_fifo_read;
  packet_t txrr_fifo_packet;

  etx_if etx_bus ();

  // Far-side wait levels
  assign etx_bus.etx_rd_wait = etx_rd_wait;
  assign etx_bus.etx_wr_wait = etx_wr_wait;

  // ########################################
  // Source FIFOs
  // ########################################
  etx_fifo u_txwr_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (wr_push),
    .push_packet  (wr_packet),
    .pop          (txwr_fifo_read),
    .full         (wr_full),
    .empty        (txwr_fifo_empty),
    .head_packet  (txwr_fifo_packet)
  );

  etx_fifo u_txrd_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (rd_push),
    .push_packet  (rd_packet),
    .pop          (txrd_fifo_read),
    .full         (rd_full),
    .empty        (txrd_fifo_empty),
    .head_packet  (txrd_fifo_packet)
  );

  etx_fifo u_txrr_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (rr_push),
    .push_packet  (rr_packet),
    .pop          (txrr_fifo_read),
    .full         (rr_full),
    .empty        (txrr_fifo_empty),
    .head_packet  (txrr_fifo_packet)
  );

  // ########################################
  // Arbiter and output stage
  // ########################################
  etx_arbiter u_arbiter (
    .tx_lclk_div4        (tx_lclk_div4),
    .reset               (reset),
    .ecfg_tx_ctrlmode_bp (ecfg_tx_ctrlmode_bp),
    .ecfg_tx_ctrlmode    (ecfg_tx_ctrlmode),
    .txwr_fifo_empty     (txwr_fifo_empty),
    .txwr_fifo_packet    (txwr_fifo_packet),
    .txwr_fifo_read      (txwr_fifo_read),
    .txrd_fifo_empty     (txrd_fifo_empty),
    .txrd_fifo_packet    (txrd_fifo_packet),
    .txrd_fifo_read      (txrd_fifo_read),
    .txrr_fifo_empty     (txrr_fifo_empty),
    .txrr_fifo_packet    (txrr_fifo_packet),
    .txrr_fifo_read      (txrr_fifo_read),
    .etx                 (etx_bus.arb)
  );

  etx_io u_io (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .etx          (etx_bus.io),
    .tx_ready     (tx_ready),
    .tx_valid     (tx_valid),
    .tx_packet    (tx_packet)
  );

endmodule

`default_nettype wire

// ==== sim/tb_etx.sv ====
/*
 Table-driven check of the transmit path; every row must drain completely before the next
 starts, and tx_ready stays low while a row pushes its packets
*/
`timescale 1ns/1ps
`default_nettype none

`include "etx_macros.svh"

module tb_etx;
  import etx_pkg::*;

  localparam int NUM_ROWS       = 7;
  localparam int TIMEOUT_CYCLES = 100;

  // One stimulus row; expected order is built from these fields
  typedef struct packed {
    logic [3:0] nwr;
    logic [3:0] nrd;
    logic [3:0] nrr;
    logic       bp;
    ctrlmode_t  mode;
    logic       wr_wait;
    logic       rd_wait;
    logic [7:0] stall;
    logic       check_full;
  } row_t;

  logic      tx_lclk_div4;
  logic      reset;
  logic      ecfg_tx_ctrlmode_bp;
  ctrlmode_t ecfg_tx_ctrlmode;
  logic      wr_push;
  logic      rd_push;
  logic      rr_push;
  packet_t   wr_packet;
  packet_t   rd_packet;
  packet_t   rr_packet;
  logic      wr_full;
  logic      rd_full;
  logic      rr_full;
  logic      etx_rd_wait;
  logic      etx_wr_wait;
  logic      tx_ready;
  logic      tx_valid;
  packet_t   tx_packet;

  row_t    rows [NUM_ROWS];
  packet_t wr_pkts [$];
  packet_t rd_pkts [$];
  packet_t rr_pkts [$];
  packet_t exp_q [$];
  int      n_first;
  int      row_idx;
  int      row_errors;
  int      errors;
  int      failed_rows;
  bit      timed_out;

  etx_top etx_top_i (
    .tx_lclk_div4        (tx_lclk_div4),
    .reset               (reset),
    .ecfg_tx_ctrlmode_bp (ecfg_tx_ctrlmode_bp),
    .ecfg_tx_ctrlmode    (ecfg_tx_ctrlmode),
    .wr_push             (wr_push),
    .wr_packet           (wr_packet),
    .wr_full             (wr_full),
    .rd_push             (rd_push),
    .rd_packet           (rd_packet),
    .rd_full             (rd_full),
    .rr_push             (rr_push),
    .rr_packet           (rr_packet),
    .rr_full             (rr_full),
    .etx_rd_wait         (etx_rd_wait),
    .etx_wr_wait         (etx_wr_wait),
    .tx_ready            (tx_ready),
    .tx_valid            (tx_valid),
    .tx_packet           (tx_packet)
  );

  // 40 ns period
  always #20 tx_lclk_div4 = ~tx_lclk_div4;

  // ########################################
  // Reference model
  // ########################################
  function automatic packet_t random_packet();
    packet_t p;
    p = '0;
    repeat (4)
      p = (p << 32) | packet_t'($urandom());
    return p;
  endfunction

  // Bits 7 to 4 take the configured mode when bypass is on
  function automatic packet_t override_mode(input packet_t pkt, input logic bp,
                                            input ctrlmode_t mode);
    packet_t p;
    p = pkt;
    if (bp)
      p[7:4] = mode;
    return p;
  endfunction

  // Classes free under the waits go first, the held ones follow in priority order
  task automatic build_expected(input row_t r);
    exp_q.delete();
    if (!r.wr_wait)
      foreach (wr_pkts[i]) exp_q.push_back(override_mode(wr_pkts[i], r.bp, r.mode));
    if (!r.rd_wait)
      foreach (rd_pkts[i]) exp_q.push_back(override_mode(rd_pkts[i], r.bp, r.mode));
    if (!r.wr_wait)
      foreach (rr_pkts[i]) exp_q.push_back(rr_pkts[i]);
    n_first = exp_q.size();
    if (r.wr_wait)
      foreach (wr_pkts[i]) exp_q.push_back(override_mode(wr_pkts[i], r.bp, r.mode));
    if (r.rd_wait)
      foreach (rd_pkts[i]) exp_q.push_back(override_mode(rd_pkts[i], r.bp, r.mode));
    if (r.wr_wait)
      foreach (rr_pkts[i]) exp_q.push_back(rr_pkts[i]);
  endtask

  // ########################################
  // Compare tasks
  // ########################################
  task automatic compare_packet(input string name, input packet_t got, input packet_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      row_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      row_errors++;
    end
  endtask

  // ########################################
  // Stimulus and collection
  // ########################################

  // Every source starts on the same edge
  task automatic push_row(input row_t r);
    int n;
    n = r.nwr;
    if (r.nrd > n)
      n = r.nrd;
    if (r.nrr > n)
      n = r.nrr;
    for (int k = 0; k < n; k++)
    begin
      @(posedge tx_lclk_div4);
      wr_push   <= (k < r.nwr);
      wr_packet <= (k < r.nwr) ? wr_pkts[k] : '0;
      rd_push   <= (k < r.nrd);
      rd_packet <= (k < r.nrd) ? rd_pkts[k] : '0;
      rr_push   <= (k < r.nrr);
      rr_packet <= (k < r.nrr) ? rr_pkts[k] : '0;
    end
    @(posedge tx_lclk_div4);
    wr_push <= 1'b0;
    rd_push <= 1'b0;
    rr_push <= 1'b0;
  endtask

  task automatic wait_full();
    int cycles;
    cycles = 0;
    @(negedge tx_lclk_div4);
    while (!wr_full && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge tx_lclk_div4);
      cycles++;
    end
    if (!wr_full)
      $display("Timeout: wr_full never rose in test %0d", row_idx);
    compare_flag("wr_full", wr_full, 1'b1);
  endtask

  // Handshake seen at the falling edge completes on the next rising edge
  task automatic collect_packets(input int first, input int last);
    int cycles;
    for (int i = first; i < last && !timed_out; i++)
    begin
      cycles = 0;
      @(negedge tx_lclk_div4);
      while (!(tx_valid && tx_ready) && cycles < TIMEOUT_CYCLES)
      begin
        @(negedge tx_lclk_div4);
        cycles++;
      end
      if (!(tx_valid && tx_ready))
      begin
        $display("Timeout: packet %0d of test %0d never reached the output", i, row_idx);
        timed_out = 1'b1;
        row_errors++;
      end
      else
      begin
        compare_packet("tx_packet", tx_packet, exp_q[i]);
        @(posedge tx_lclk_div4);
      end
    end
  endtask

  task automatic run_row(input row_t r);
    row_errors = 0;
    wr_pkts.delete();
    rd_pkts.delete();
    rr_pkts.delete();
    repeat (r.nwr) wr_pkts.push_back(random_packet());
    repeat (r.nrd) rd_pkts.push_back(random_packet());
    repeat (r.nrr) rr_pkts.push_back(random_packet());
    build_expected(r);
    @(posedge tx_lclk_div4);
    ecfg_tx_ctrlmode_bp <= r.bp;
    ecfg_tx_ctrlmode    <= r.mode;
    etx_wr_wait         <= r.wr_wait;
    etx_rd_wait         <= r.rd_wait;
    tx_ready            <= 1'b0;
    // Nothing left over from the previous row
    @(negedge tx_lclk_div4);
    compare_flag("tx_valid", tx_valid, 1'b0);
    compare_flag("wr_full", wr_full, 1'b0);
    compare_flag("rd_full", rd_full, 1'b0);
    compare_flag("rr_full", rr_full, 1'b0);
    push_row(r);
    if (r.check_full)
      wait_full();
    repeat (r.stall) @(posedge tx_lclk_div4);
    @(posedge tx_lclk_div4);
    tx_ready <= 1'b1;
    collect_packets(0, n_first);
    // Release the waits, held packets follow
    if (!timed_out && n_first < exp_q.size())
    begin
      @(posedge tx_lclk_div4);
      etx_wr_wait <= 1'b0;
      etx_rd_wait <= 1'b0;
      collect_packets(n_first, exp_q.size());
    end
    errors += row_errors;
    if (row_errors != 0)
      failed_rows++;
    $display("test %0d: %0d packets, %s", row_idx, exp_q.size(),
             (row_errors == 0) ? "ok" : "mismatch");
  endtask

  // ########################################
  // Main sequence
  // ########################################
  initial
  begin
    tx_lclk_div4        = 1'b0;
    reset               = 1'b1;
    ecfg_tx_ctrlmode_bp = 1'b0;
    ecfg_tx_ctrlmode    = '0;
    wr_push             = 1'b0;
    rd_push             = 1'b0;
    rr_push             = 1'b0;
    wr_packet           = '0;
    rd_packet           = '0;
    rr_packet           = '0;
    etx_rd_wait         = 1'b0;
    etx_wr_wait         = 1'b0;
    tx_ready            = 1'b0;
    errors              = 0;
    failed_rows         = 0;
    timed_out           = 1'b0;
    void'($urandom(32'ha65a_0fae));

    //        nwr   nrd   nrr   bp    mode   wrw   rdw   stall check_full
    // Mode set but bypass low, packets pass unchanged
    rows[0] = '{4'd1, 4'd0, 4'd0, 1'b0, 4'h9, 1'b0, 1'b0, 8'd0, 1'b0};
    rows[1] = '{4'd0, 4'd1, 4'd0, 1'b0, 4'h6, 1'b0, 1'b0, 8'd0, 1'b0};
    rows[2] = '{4'd0, 4'd0, 4'd1, 1'b0, 4'h3, 1'b0, 1'b0, 8'd0, 1'b0};
    // Override on writes and read requests only
    rows[3] = '{4'd1, 4'd1, 4'd1, 1'b1, 4'ha, 1'b0, 1'b0, 8'd0, 1'b0};
    // All three held behind a stalled receiver
    rows[4] = '{4'd1, 4'd1, 4'd1, 1'b0, 4'h0, 1'b0, 1'b0, 8'd6, 1'b0};
    // Write wait lets the read request overtake
    rows[5] = '{4'd1, 4'd1, 4'd1, 1'b1, 4'h5, 1'b1, 1'b0, 8'd2, 1'b0};
    // Two beyond depth, one in the I/O stage and one in the arbiter
    rows[6] = '{4'(`ETX_FIFO_DEPTH + 2), 4'd0, 4'd0, 1'b0, 4'h0, 1'b0, 1'b0, 8'd2, 1'b1};

    repeat (4) @(posedge tx_lclk_div4);
    reset <= 1'b0;

    for (row_idx = 0; row_idx < NUM_ROWS && !timed_out; row_idx++)
      run_row(rows[row_idx]);

    $display("%0d tests run, %0d failing, %0d errors", row_idx, failed_rows, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/etx_pkg.sv
hw/etx_if.sv
hw/etx_fifo.sv
hw/etx_arbiter.sv
hw/etx_io.sv
hw/etx_top.sv
sim/tb_etx.sv

// ==== Bender.yml ====
package:
  name: etx

sources:
  - include_dirs:
      - hw
    files:
      - hw/etx_pkg.sv
      - hw/etx_if.sv
      - hw/etx_fifo.sv
      - hw/etx_arbiter.sv
      - hw/etx_io.sv
      - hw/etx_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_etx.sv
